// File: src.f
+incdir+test
common/osd_pkg.sv
verilog/osd_dii_buffer.sv
statctrl/osd_statctrlif.sv
verilog/osd_regbank.sv
verilog/osd_debug_module.sv
test/tb_osd_debug_module.sv

// File: test/osd_tb_packets.svh
// expected response flits in arrival order
logic [15:0] exp_data [$];
logic        exp_last [$];
logic        exp_count [$];    // counter value, captured and not compared
logic [15:0] counter_reads [$];
logic [15:0] model_scratch [3];
logic        model_stall;

task automatic expect_flit(input logic [15:0] data, input logic last, input logic count);
   exp_data.push_back(data);
   exp_last.push_back(last);
   exp_count.push_back(count);
endtask

// called 1 ns after an edge, returns 1 ns after the edge that took the flit
task automatic put_flit(input logic [15:0] data, input logic last);
   in_data = data;
   in_last = last;
   in_valid = 1'b1;
   do
      @(posedge clk);
   while (!in_ready);
   #1;
   in_valid = 1'b0;
endtask

// one request packet, with its expected answer queued first
task automatic send_req(input logic [1:0] ptype, input logic burst, input logic write,
                        input logic [1:0] size, input logic [15:0] addr,
                        input logic [15:0] value, input logic with_value);
   osd_pkg::dii_flit hdr;
   logic [9:0]       src;
   logic             ext;
   logic             err;
   src = 10'($urandom);
   ext = (addr[15:9] != 7'h00);
   err = burst || (size != 2'd1) || (write && !with_value);
   if (ext)
      err = err || (addr > 16'h0203) || (write && addr == 16'h0203);
   else if (write)
      err = err || (addr != 16'h0003);
   else
      err = err || (addr != 16'h0000 && addr != 16'h0001);
   // nonzero type and reads with a trailing flit get no answer
   if (ptype == 2'b00 && (write || !with_value)) begin
      expect_flit({6'h00, src}, 1'b0, 1'b0);
      expect_flit({4'h0, write, err, DUT_ID}, write || err, 1'b0);
      if (!write && !err) begin
         if (!ext)
            expect_flit(addr[0] ? 16'h0002 : 16'h0005, 1'b1, 1'b0);
         else if (addr == 16'h0203)
            expect_flit(16'h0000, 1'b1, 1'b1);
         else
            expect_flit(model_scratch[addr[1:0]], 1'b1, 1'b0);
      end else if (write && !err) begin
         if (ext)
            model_scratch[addr[1:0]] = value;
         else
            model_stall = value[0];
      end
   end
   hdr.raw = '0;
   hdr.req_hdr.pkt_type = ptype;
   hdr.req_hdr.burst = burst;
   hdr.req_hdr.write = write;
   hdr.req_hdr.size = size;
   hdr.req_hdr.src = src;
   put_flit(16'h0001, 1'b0); // destination, ignored by the module
   put_flit(hdr.raw, 1'b0);
   put_flit(addr, !with_value);
   if (with_value)
      put_flit(value, 1'b1);
endtask

task automatic read_reg(input logic [15:0] addr);
   send_req(2'b00, 1'b0, 1'b0, 2'd1, addr, 16'h0000, 1'b0);
endtask

task automatic write_reg(input logic [15:0] addr, input logic [15:0] value);
   send_req(2'b00, 1'b0, 1'b1, 2'd1, addr, value, 1'b1);
endtask

// File: test/tb_osd_debug_module.sv
`timescale 1ns/10ps
`default_nettype none

module tb_osd_debug_module;

   localparam logic [9:0] DUT_ID = 10'h02A;
   localparam int NUM_PACKETS = 44;

   logic        clk;
   logic        rst;
   logic [9:0]  id;
   logic [15:0] in_data;
   logic        in_last;
   logic        in_valid;
   logic        in_ready;
   logic [15:0] out_data;
   logic        out_last;
   logic        out_valid;
   logic        out_ready;
   logic        stall;

   `include "osd_tb_packets.svh"

   osd_debug_module dut (
      .clk, .rst, .id,
      .in_data, .in_last, .in_valid, .in_ready,
      .out_data, .out_last, .out_valid, .out_ready,
      .stall
   );

   always #2 clk = ~clk;

   // random back-pressure, about 30 percent of cycles
   always @(posedge clk) begin
      #1 out_ready = ($urandom % 10) >= 3;
   end

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic drain;
      do begin
         @(posedge clk);
         #1;
      end while (exp_data.size() != 0);
   endtask

   task automatic check_stall;
      assert (stall === model_stall)
         else stop_run($sformatf("Error at %0t ns: stall %b, expected %b",
                                 $time, stall, model_stall));
   endtask

   // every outgoing handshake against the queue head, seen mid cycle
   always @(negedge clk) begin
      if (!rst && out_valid) begin
         assert (exp_data.size() != 0)
            else stop_run("a response flit was sent while no response was expected");
         if (out_ready) begin
            if (exp_count[0]) begin
               counter_reads.push_back(out_data);
            end else begin
               assert (out_data == exp_data[0])
                  else stop_run($sformatf("Error at %0t ns: out_data %h, expected %h",
                                          $time, out_data, exp_data[0]));
            end
            assert (out_last == exp_last[0])
               else stop_run($sformatf("Error at %0t ns: out_last %b, expected %b",
                                       $time, out_last, exp_last[0]));
            exp_data.delete(0);
            exp_last.delete(0);
            exp_count.delete(0);
         end
      end
   end

   initial begin
      #((NUM_PACKETS * 400 + 5) * 4);
      stop_run("Timeout: the responses did not finish in the allowed time");
   end

   initial begin
      int pick;
      void'($urandom(15468));
      clk = 1'b0;
      rst = 1'b1;
      id = DUT_ID;
      in_data = '0;
      in_last = 1'b0;
      in_valid = 1'b0;
      out_ready = 1'b0;
      model_stall = 1'b1;
      for (int i = 0; i < 3; i++)
         model_scratch[i] = '0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;

      read_reg(16'h0000);
      read_reg(16'h0001);
      drain();
      check_stall();
      write_reg(16'h0003, 16'h0000);
      drain();
      check_stall();
      write_reg(16'h0003, 16'h0001);
      drain();
      check_stall();

      for (int i = 0; i < 3; i++)
         write_reg(16'h0200 + 16'(i), 16'($urandom));
      for (int i = 0; i < 3; i++)
         read_reg(16'h0200 + 16'(i));
      write_reg(16'h0003, 16'h0000); // counter runs from here
      drain();
      read_reg(16'h0203);
      drain();
      read_reg(16'h0203);
      drain();
      assert (counter_reads.size() == 2 && counter_reads[1] > counter_reads[0])
         else stop_run("the cycle counter did not advance while the module ran");

      // error answers
      read_reg(16'h0002);
      send_req(2'b00, 1'b0, 1'b0, 2'd2, 16'h0200, 16'h0000, 1'b0);
      send_req(2'b00, 1'b1, 1'b0, 2'd1, 16'h0000, 16'h0000, 1'b0);
      write_reg(16'h0203, 16'h1234);
      read_reg(16'h0204);
      send_req(2'b00, 1'b0, 1'b1, 2'd1, 16'h0201, 16'hbeef, 1'b0);
      read_reg(16'h0201);
      send_req(2'b00, 1'b1, 1'b1, 2'd1, 16'h0003, 16'h0001, 1'b1);
      drain();
      check_stall();

      // dropped packets, then a normal read
      send_req(2'b01, 1'b0, 1'b0, 2'd1, 16'h0000, 16'h0000, 1'b0);
      send_req(2'b00, 1'b0, 1'b0, 2'd1, 16'h0000, 16'h5555, 1'b1);
      read_reg(16'h0001);

      // back to back under back-pressure
      for (int i = 0; i < 20; i++) begin
         pick = $urandom % 3;
         if (pick == 0)
            write_reg(16'h0200 + 16'($urandom % 3), 16'($urandom));
         else if (pick == 1)
            read_reg(16'h0200 + 16'($urandom % 3));
         else
            read_reg(16'($urandom % 2));
      end
      drain();
      repeat (10) @(posedge clk);

      if (exp_data.size() == 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         stop_run("expected response flits were still missing at the end of the run");
      end
   end

endmodule

`default_nettype wire

// File: verilog/osd_debug_module.sv
`timescale 1ns/10ps
`default_nettype none

module osd_debug_module (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire logic [9:0]                id,
   input  wire logic [osd_pkg::FLIT_W-1:0] in_data,
   input  wire logic                      in_last,
   input  wire logic                      in_valid,
   output logic                           in_ready,
   output logic [osd_pkg::FLIT_W-1:0]     out_data,
   output logic                           out_last,
   output logic                           out_valid,
   input  wire logic                      out_ready,
   output logic                           stall
);

   logic [osd_pkg::FLIT_W-1:0] buf_data;
   logic                       buf_last;
   logic                       buf_valid;
   logic                       buf_ready;

   logic        reg_request;
   logic        reg_write;
   logic [15:0] reg_addr;
   logic [1:0]  reg_size;
   logic [15:0] reg_wdata;
   logic        reg_ack;
   logic        reg_err;
   logic [15:0] reg_rdata;

   osd_dii_buffer u_buffer (
      .clk, .rst,
      .in_data, .in_last, .in_valid, .in_ready,
      .buf_data, .buf_last, .buf_valid, .buf_ready
   );

   osd_statctrlif u_statctrl (
      .clk, .rst, .id,
      .buf_data, .buf_last, .buf_valid, .buf_ready,
      .out_data, .out_last, .out_valid, .out_ready,
      .reg_request, .reg_write, .reg_addr, .reg_size, .reg_wdata,
      .reg_ack, .reg_err, .reg_rdata,
      .stall
   );

   osd_regbank u_regbank (
      .clk, .rst, .stall,
      .reg_request, .reg_write, .reg_addr, .reg_size, .reg_wdata,
      .reg_ack, .reg_err, .reg_rdata
   );

endmodule

`default_nettype wire

// File: verilog/osd_regbank.sv
`timescale 1ns/10ps
`default_nettype none

module osd_regbank (
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic        stall,
   input  wire logic        reg_request,
   input  wire logic        reg_write,
   input  wire logic [15:0] reg_addr,
   input  wire logic [1:0]  reg_size,
   input  wire logic [15:0] reg_wdata,
   output logic             reg_ack,
   output logic             reg_err,
   output logic [15:0]      reg_rdata
);

   logic [15:0] scratch [osd_pkg::REGBANK_SIZE-1];
   logic [15:0] counter;
   logic [15:0] offset;
   logic [1:0]  idx;
   logic        in_range;
   logic        is_counter;
   logic        bad;
   logic        new_req;

   assign offset = reg_addr - osd_pkg::EXT_ADDR_BASE;
   assign in_range = (reg_addr >= osd_pkg::EXT_ADDR_BASE) &&
                     (offset < osd_pkg::REGBANK_SIZE);
   assign idx = offset[1:0];
   assign is_counter = (idx == 2'(osd_pkg::REGBANK_SIZE - 1));
   assign bad = !in_range || (reg_size != osd_pkg::REQ_SIZE_16) ||
                (reg_write && is_counter);

   // answer once per request, the cycle after it rises
   assign new_req = reg_request && !reg_ack && !reg_err;

   always_ff @(posedge clk) begin
      if (rst) begin
         reg_ack <= 1'b0;
         reg_err <= 1'b0;
         counter <= '0;
         for (int i = 0; i < osd_pkg::REGBANK_SIZE - 1; i++)
            scratch[i] <= '0;
      end else begin
         reg_ack <= 1'b0;
         reg_err <= 1'b0;
         if (!stall)
            counter <= counter + 16'd1;
         if (new_req) begin
            if (bad) begin
               reg_err <= 1'b1;
            end else begin
               reg_ack <= 1'b1;
               if (reg_write)
                  scratch[idx] <= reg_wdata;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (new_req && !reg_write) begin
         if (is_counter)
            reg_rdata <= counter;
         else
            reg_rdata <= scratch[idx];
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      reg_ack || reg_err |-> !(reg_ack && reg_err) && $past(reg_request));

endmodule

`default_nettype wire

// File: statctrl/osd_statctrlif.sv
`timescale 1ns/10ps
`default_nettype none

module osd_statctrlif (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire logic [9:0]                id,
   input  wire logic [osd_pkg::FLIT_W-1:0] buf_data,
   input  wire logic                      buf_last,
   input  wire logic                      buf_valid,
   output logic                           buf_ready,
   output logic [osd_pkg::FLIT_W-1:0]     out_data,
   output logic                           out_last,
   output logic                           out_valid,
   input  wire logic                      out_ready,
   output logic                           reg_request,
   output logic                           reg_write,
   output logic [15:0]                    reg_addr,
   output logic [1:0]                     reg_size,
   output logic [15:0]                    reg_wdata,
   input  wire logic                      reg_ack,
   input  wire logic                      reg_err,
   input  wire logic [15:0]               reg_rdata,
   output logic                           stall
);

   osd_pkg::dii_flit flit;

   logic [3:0]  state;
   logic [3:0]  nxt_state;
   logic        stall_r;
   logic        nxt_stall;

   logic        req_write;
   logic [1:0]  req_size;
   logic [15:0] req_addr;
   logic [15:0] req_value;
   logic [9:0]  resp_dest;
   logic        resp_error;
   logic        nxt_req_write;
   logic [1:0]  nxt_req_size;
   logic [15:0] nxt_req_addr;
   logic [15:0] nxt_req_value;
   logic [9:0]  nxt_resp_dest;
   logic        nxt_resp_error;

   logic        addr_ext;
   logic        req_ext;
   logic        local_err;

   assign flit = buf_data;
   assign addr_ext = (flit.raw >= osd_pkg::EXT_ADDR_BASE);
   assign req_ext = (req_addr >= osd_pkg::EXT_ADDR_BASE);

   assign stall = osd_pkg::CAN_STALL && stall_r;

   assign reg_write = req_write;
   assign reg_addr = req_addr;
   assign reg_size = req_size;
   assign reg_wdata = req_value;

   // which local accesses are legal, by address flit
   always_comb begin
      case (flit.raw)
         osd_pkg::REG_MODID,
         osd_pkg::REG_VERSION: local_err = req_write; // read only
         osd_pkg::REG_CS:      local_err = !req_write || !osd_pkg::CAN_STALL;
         default:              local_err = 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= osd_pkg::ST_IDLE;
         stall_r <= 1'b1;
      end else begin
         state <= nxt_state;
         stall_r <= nxt_stall;
      end
   end

   always_ff @(posedge clk) begin
      req_write <= nxt_req_write;
      req_size <= nxt_req_size;
      req_addr <= nxt_req_addr;
      req_value <= nxt_req_value;
      resp_dest <= nxt_resp_dest;
      resp_error <= nxt_resp_error;
   end

   always_comb begin
      nxt_state = state;
      nxt_stall = stall_r;
      nxt_req_write = req_write;
      nxt_req_size = req_size;
      nxt_req_addr = req_addr;
      nxt_req_value = req_value;
      nxt_resp_dest = resp_dest;
      nxt_resp_error = resp_error;

      buf_ready = 1'b0;
      out_valid = 1'b0;
      out_data = '0;
      out_last = 1'b0;
      reg_request = 1'b0;

      case (state)
         osd_pkg::ST_IDLE: begin
            buf_ready = 1'b1; // destination flit, not needed
            if (buf_valid && !buf_last)
               nxt_state = osd_pkg::ST_HEADER;
         end
         osd_pkg::ST_HEADER: begin
            buf_ready = 1'b1;
            if (buf_valid) begin
               nxt_req_write = flit.req_hdr.write;
               nxt_req_size = flit.req_hdr.size;
               nxt_resp_dest = flit.req_hdr.src;
               nxt_resp_error = flit.req_hdr.burst ||
                                (flit.req_hdr.size != osd_pkg::REQ_SIZE_16);
               if (buf_last)
                  nxt_state = osd_pkg::ST_IDLE;
               else if (flit.req_hdr.pkt_type != osd_pkg::REQ_TYPE_REG)
                  nxt_state = osd_pkg::ST_DROP;
               else
                  nxt_state = osd_pkg::ST_ADDR;
            end
         end
         osd_pkg::ST_ADDR: begin
            buf_ready = 1'b1;
            if (buf_valid) begin
               nxt_req_addr = flit.raw;
               if (!addr_ext)
                  nxt_resp_error = resp_error || local_err;
               if (!req_write) begin
                  nxt_req_value = (flit.raw == osd_pkg::REG_MODID) ?
                                  osd_pkg::MOD_ID : osd_pkg::MOD_VERSION;
               end
               if (req_write) begin
                  if (buf_last) begin
                     nxt_resp_error = 1'b1; // value flit missing
                     nxt_state = osd_pkg::ST_RESP_DEST;
                  end else begin
                     nxt_state = osd_pkg::ST_WRITE;
                  end
               end else if (!buf_last) begin
                  nxt_state = osd_pkg::ST_DROP;
               end else if (nxt_resp_error || !addr_ext) begin
                  nxt_state = osd_pkg::ST_RESP_DEST;
               end else begin
                  nxt_state = osd_pkg::ST_EXT;
               end
            end
         end
         osd_pkg::ST_WRITE: begin
            buf_ready = 1'b1;
            if (buf_valid) begin
               nxt_req_value = flit.raw;
               if (!buf_last) begin
                  nxt_state = osd_pkg::ST_DROP;
               end else if (resp_error) begin
                  nxt_state = osd_pkg::ST_RESP_DEST;
               end else if (req_ext) begin
                  nxt_state = osd_pkg::ST_EXT;
               end else begin
                  // only CS gets here without error
                  nxt_stall = flit.raw[0];
                  nxt_state = osd_pkg::ST_RESP_DEST;
               end
            end
         end
         osd_pkg::ST_EXT: begin
            reg_request = 1'b1;
            if (reg_ack || reg_err) begin
               nxt_resp_error = reg_err;
               if (!req_write)
                  nxt_req_value = reg_rdata;
               nxt_state = osd_pkg::ST_RESP_DEST;
            end
         end
         osd_pkg::ST_RESP_DEST: begin
            out_valid = 1'b1;
            out_data = {6'h00, resp_dest};
            if (out_ready)
               nxt_state = osd_pkg::ST_RESP_SRC;
         end
         osd_pkg::ST_RESP_SRC: begin
            out_valid = 1'b1;
            out_data = {4'h0, req_write, resp_error, id};
            out_last = req_write || resp_error;
            if (out_ready)
               nxt_state = out_last ? osd_pkg::ST_IDLE : osd_pkg::ST_RESP_VALUE;
         end
         osd_pkg::ST_RESP_VALUE: begin
            out_valid = 1'b1;
            out_data = req_value;
            out_last = 1'b1;
            if (out_ready)
               nxt_state = osd_pkg::ST_IDLE;
         end
         osd_pkg::ST_DROP: begin
            buf_ready = 1'b1;
            if (buf_valid && buf_last)
               nxt_state = osd_pkg::ST_IDLE;
         end
         default: nxt_state = osd_pkg::ST_IDLE;
      endcase
   end

   // request held with a stable address until the bank answers
   assert property (@(posedge clk) disable iff (rst)
      reg_request && !reg_ack && !reg_err |=> reg_request && $stable(reg_addr));

   assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

`default_nettype wire

// File: verilog/osd_dii_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module osd_dii_buffer (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire logic [osd_pkg::FLIT_W-1:0] in_data,
   input  wire logic                      in_last,
   input  wire logic                      in_valid,
   output logic                           in_ready,
   output logic [osd_pkg::FLIT_W-1:0]     buf_data,
   output logic                           buf_last,
   output logic                           buf_valid,
   input  wire logic                      buf_ready
);

   logic [osd_pkg::FLIT_W-1:0] mem_data [2];
   logic                       mem_last [2];
   logic                       wr_ptr;
   logic                       rd_ptr;
   logic [1:0]                 count;
   logic [1:0]                 nxt_count;
   logic                       push;
   logic                       pop;

   assign push = in_valid && in_ready;
   assign pop = buf_valid && buf_ready;
   assign nxt_count = count + 2'(push) - 2'(pop);

   assign buf_valid = (count != 2'd0);
   assign buf_data = mem_data[rd_ptr];
   assign buf_last = mem_last[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count <= 2'd0;
         in_ready <= 1'b0; // held low through reset
      end else begin
         if (push)
            wr_ptr <= ~wr_ptr;
         if (pop)
            rd_ptr <= ~rd_ptr;
         count <= nxt_count;
         in_ready <= (nxt_count != 2'd2);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem_data[wr_ptr] <= in_data;
         mem_last[wr_ptr] <= in_last;
      end
   end

   assert property (@(posedge clk) disable iff (rst) push |-> count != 2'd2);
   assert property (@(posedge clk) disable iff (rst) count <= 2'd2); // catches pop when empty

endmodule

`default_nettype wire

// File: common/osd_pkg.sv
`default_nettype none

package osd_pkg;

   localparam int FLIT_W = 16;

   // a flit seen as plain data or as a request header
   typedef union packed {
      logic [FLIT_W-1:0] raw;
      struct packed {
         logic [1:0] pkt_type;
         logic       burst;
         logic       write;
         logic [1:0] size;
         logic [9:0] src;
      } req_hdr;
   } dii_flit;

   localparam logic [1:0] REQ_TYPE_REG = 2'b00; // register access, all else is dropped
   localparam logic [1:0] REQ_SIZE_16  = 2'b01;

   localparam logic [15:0] EXT_ADDR_BASE = 16'h0200;
   localparam logic [15:0] REG_MODID     = 16'h0000;
   localparam logic [15:0] REG_VERSION   = 16'h0001;
   localparam logic [15:0] REG_CS        = 16'h0003;

   localparam logic [15:0] MOD_ID      = 16'h0005;
   localparam logic [15:0] MOD_VERSION = 16'h0002;
   localparam logic        CAN_STALL   = 1'b1;

   localparam int REGBANK_SIZE = 4; // last entry is the counter

   // status/control interface states
   localparam logic [3:0] ST_IDLE       = 4'd0;
   localparam logic [3:0] ST_HEADER     = 4'd1;
   localparam logic [3:0] ST_ADDR       = 4'd2;
   localparam logic [3:0] ST_WRITE      = 4'd3;
   localparam logic [3:0] ST_EXT        = 4'd4;
   localparam logic [3:0] ST_RESP_DEST  = 4'd5;
   localparam logic [3:0] ST_RESP_SRC   = 4'd6;
   localparam logic [3:0] ST_RESP_VALUE = 4'd7;
   localparam logic [3:0] ST_DROP       = 4'd8;

endpackage

`default_nettype wire
